// ==== common/tetris_pkg.sv ====
package tetris_pkg;

	// ------------------------------------------------------------
	// board geometry
	// ------------------------------------------------------------
	localparam int board_cols = 6;
	localparam int board_rows = 12;
	// two hidden rows above the visible board
	localparam int map_rows = 14;
	localparam int pieces_per_game = 16;

	typedef logic [2:0] col_t;
	// 0 is an empty column, else topmost filled row + 1
	typedef logic [3:0] height_t;
	// bit index is the column
	typedef logic [board_cols-1:0] map_row_t;
	typedef logic [3:0] score_t;

	typedef enum logic [2:0] {
		shape_square = 3'd0,
		shape_vbar = 3'd1,
		shape_hbar = 3'd2,
		shape_hook_r = 3'd3,
		shape_hook_l = 3'd4,
		shape_foot = 3'd5,
		shape_s_vert = 3'd6,
		shape_z_flat = 3'd7
	} shape_t;

	typedef enum logic [1:0] {
		st_accept = 2'd0,
		st_place = 2'd1,
		st_clear = 2'd2,
		st_report = 2'd3
	} ctrl_state_t;

	// ------------------------------------------------------------
	// piece geometry
	// ------------------------------------------------------------

	// max over touched columns of height + column offset
	function automatic height_t landing_row(input shape_t shape, input height_t h0,
		input height_t h1, input height_t h2, input height_t h3);
		height_t v [4];
		height_t best;
		v = '{h0, h1, 4'd0, 4'd0};
		case (shape)
			shape_vbar: v[1] = 4'd0;
			shape_hbar: v = '{h0, h1, h2, h3};
			shape_hook_r: v[1] = h1 + 4'd2;
			shape_hook_l: v = '{h0 + 4'd1, h1, h2, 4'd0};
			shape_s_vert: v[1] = h1 + 4'd1;
			shape_z_flat: v = '{h0 + 4'd1, h1 + 4'd1, h2, 4'd0};
			default: ;
		endcase
		best = v[0];
		for (int k = 1; k < 4; k++) begin
			if (v[k] > best)
				best = v[k];
		end
		return best;
	endfunction

	// [row][column offset] cells of a piece anchored at its landing row
	function automatic logic [map_rows-1:0][3:0] shape_cells(input shape_t shape,
		input height_t row);
		logic [map_rows-1:0][3:0] mask;
		int d;
		mask = '0;
		for (int r = 0; r < map_rows; r++) begin
			d = r - int'(row);
			case (shape)
				shape_square: mask[r] = (d == 0 || d == 1) ? 4'b0011 : 4'b0000;
				shape_vbar: mask[r] = (d >= 0 && d <= 3) ? 4'b0001 : 4'b0000;
				shape_hbar: mask[r] = (d == 0) ? 4'b1111 : 4'b0000;
				shape_hook_r: mask[r] = (d == 0) ? 4'b0011 :
					(d == -1 || d == -2) ? 4'b0010 : 4'b0000;
				shape_hook_l: mask[r] = (d == 0) ? 4'b0111 : (d == -1) ? 4'b0001 : 4'b0000;
				shape_foot: mask[r] = (d == 0) ? 4'b0011 :
					(d == 1 || d == 2) ? 4'b0001 : 4'b0000;
				shape_s_vert: mask[r] = (d == 0) ? 4'b0011 : (d == -1) ? 4'b0010 :
					(d == 1) ? 4'b0001 : 4'b0000;
				default: mask[r] = (d == 0) ? 4'b0110 : (d == -1) ? 4'b0011 : 4'b0000;
			endcase
		end
		return mask;
	endfunction

endpackage

// ==== src/piece_control.sv ====
`timescale 1ns/1ps

module piece_control #(
	parameter int game_len = tetris_pkg::pieces_per_game
) (
	input logic clk,
	input logic rst_n,
	input logic in_valid,
	input logic fail_flag,
	input tetris_pkg::score_t score_in,
	input logic [tetris_pkg::board_rows*tetris_pkg::board_cols-1:0] board_in,
	output tetris_pkg::ctrl_state_t state,
	output logic take,
	output logic game_end,
	output logic score_valid,
	output logic fail,
	output logic tetris_valid,
	output tetris_pkg::score_t score,
	output logic [tetris_pkg::board_rows*tetris_pkg::board_cols-1:0] tetris
);

	localparam int cnt_w = $clog2(game_len + 1);

	tetris_pkg::ctrl_state_t state_next;
	logic [cnt_w-1:0] piece_cnt;
	logic last_piece;

	// ------------------------------------------------------------
	// accept -> place -> clear -> report
	// ------------------------------------------------------------
	always_comb begin
		state_next = state;
		case (state)
			tetris_pkg::st_accept: begin
				if (in_valid)
					state_next = tetris_pkg::st_place;
			end
			tetris_pkg::st_place: state_next = tetris_pkg::st_clear;
			tetris_pkg::st_clear: state_next = tetris_pkg::st_report;
			default: state_next = tetris_pkg::st_accept;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			state <= tetris_pkg::st_accept;
		else
			state <= state_next;
	end

	// pieces already finished in this game
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			piece_cnt <= '0;
		else if (game_end)
			piece_cnt <= '0;
		else if (state == tetris_pkg::st_report)
			piece_cnt <= piece_cnt + 1'b1;
	end

	assign last_piece = (piece_cnt == cnt_w'(game_len - 1));
	assign take = (state == tetris_pkg::st_accept) && in_valid;
	assign game_end = (state == tetris_pkg::st_report) && (fail_flag || last_piece);

	// outputs only live during report
	assign score_valid = (state == tetris_pkg::st_report);
	assign score = score_valid ? score_in : '0;
	assign fail = fail_flag;
	assign tetris_valid = game_end;
	assign tetris = game_end ? board_in : '0;

	// the height tracker only raises fail during report
	assert property (@(posedge clk) disable iff (!rst_n)
		fail_flag |-> state == tetris_pkg::st_report);

endmodule

// ==== board/drop_calc.sv ====
`timescale 1ns/1ps

module drop_calc (
	input logic clk,
	input logic rst_n,
	input logic take,
	input tetris_pkg::shape_t tetromino,
	input tetris_pkg::col_t position,
	input tetris_pkg::height_t [tetris_pkg::board_cols-1:0] heights,
	output tetris_pkg::shape_t shape,
	output tetris_pkg::col_t column,
	output tetris_pkg::height_t land_row
);

	tetris_pkg::height_t [3:0] col_h_next;
	tetris_pkg::height_t [3:0] col_h;

	// heights of the four columns from the piece's left edge
	// columns past the right edge read as empty
	always_comb begin
		col_h_next = '0;
		for (int k = 0; k < 4; k++) begin
			for (int c = 0; c < tetris_pkg::board_cols; c++) begin
				if (int'(position) + k == c)
					col_h_next[k] = heights[c];
			end
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			shape <= tetris_pkg::shape_square;
			column <= '0;
			col_h <= '0;
		end else if (take) begin
			shape <= tetromino;
			column <= position;
			col_h <= col_h_next;
		end
	end

	// used during place
	assign land_row = tetris_pkg::landing_row(shape, col_h[0], col_h[1], col_h[2], col_h[3]);

endmodule

// ==== board/board_store.sv ====
`timescale 1ns/1ps

module board_store (
	input logic clk,
	input logic rst_n,
	input tetris_pkg::ctrl_state_t state,
	input logic game_end,
	input tetris_pkg::shape_t shape,
	input tetris_pkg::col_t column,
	input tetris_pkg::height_t land_row,
	output tetris_pkg::map_row_t [tetris_pkg::map_rows-1:0] map,
	output tetris_pkg::score_t score_out
);

	logic [tetris_pkg::map_rows-1:0][3:0] cells;
	tetris_pkg::map_row_t [tetris_pkg::map_rows-1:0] placed;
	tetris_pkg::map_row_t [tetris_pkg::map_rows-1:0] collapsed;
	tetris_pkg::score_t full_cnt;

	// ------------------------------------------------------------
	// piece footprint, shifted over to its column
	// ------------------------------------------------------------
	always_comb begin
		cells = tetris_pkg::shape_cells(shape, land_row);
		for (int r = 0; r < tetris_pkg::map_rows; r++) begin
			placed[r] = tetris_pkg::map_row_t'({2'b00, cells[r]} << column);
		end
	end

	// ------------------------------------------------------------
	// full row removal
	// ------------------------------------------------------------
	// surviving rows are packed downward in order, the top refills empty
	always_comb begin
		int wr;
		int n_full;
		wr = 0;
		n_full = 0;
		collapsed = '0;
		for (int r = 0; r < tetris_pkg::map_rows; r++) begin
			if (r < tetris_pkg::board_rows && (&map[r])) begin
				n_full++;
			end else begin
				collapsed[wr] = map[r];
				wr++;
			end
		end
		full_cnt = tetris_pkg::score_t'(n_full);
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			map <= '0;
		end else if (game_end) begin
			map <= '0;
		end else begin
			case (state)
				tetris_pkg::st_place: map <= map | placed;
				tetris_pkg::st_clear: map <= collapsed;
				default: ;
			endcase
		end
	end

	// score counts rows cleared in this game
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			score_out <= '0;
		else if (game_end)
			score_out <= '0;
		else if (state == tetris_pkg::st_clear)
			score_out <= score_out + full_cnt;
	end

	// cells can only be lost off the top of the map, and such a
	// piece always pushes a column past the visible board
	assert property (@(posedge clk) disable iff (!rst_n)
		(state == tetris_pkg::st_place && $countones(cells) != 4) |-> ##2 game_end);

endmodule

// ==== board/height_tracker.sv ====
`timescale 1ns/1ps

module height_tracker (
	input logic clk,
	input logic rst_n,
	input tetris_pkg::ctrl_state_t state,
	input logic game_end,
	input tetris_pkg::map_row_t [tetris_pkg::map_rows-1:0] map,
	output tetris_pkg::height_t [tetris_pkg::board_cols-1:0] heights,
	output logic fail_flag
);

	logic [tetris_pkg::board_cols-1:0][tetris_pkg::map_rows-1:0] col_bits;
	tetris_pkg::height_t [tetris_pkg::board_cols-1:0] new_heights;

	// topmost filled row + 1, zero for an empty column
	function automatic tetris_pkg::height_t top_of(input logic [tetris_pkg::map_rows-1:0] bits);
		tetris_pkg::height_t h;
		h = '0;
		for (int r = 0; r < tetris_pkg::map_rows; r++) begin
			if (bits[r])
				h = tetris_pkg::height_t'(r + 1);
		end
		return h;
	endfunction

	always_comb begin
		fail_flag = 1'b0;
		for (int c = 0; c < tetris_pkg::board_cols; c++) begin
			for (int r = 0; r < tetris_pkg::map_rows; r++) begin
				col_bits[c][r] = map[r][c];
			end
			new_heights[c] = top_of(col_bits[c]);
			if (new_heights[c] > tetris_pkg::height_t'(tetris_pkg::board_rows))
				fail_flag = (state == tetris_pkg::st_report);
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			heights <= '0;
		else if (game_end)
			heights <= '0;
		else if (state == tetris_pkg::st_report)
			heights <= new_heights;
	end

endmodule

// ==== src/tetris_top.sv ====
`timescale 1ns/1ps

module tetris_top #(
	parameter int game_len = tetris_pkg::pieces_per_game
) (
	input logic clk,
	input logic rst_n,
	input logic in_valid,
	input tetris_pkg::shape_t tetromino,
	input tetris_pkg::col_t position,
	output logic score_valid,
	output logic fail,
	output logic tetris_valid,
	output tetris_pkg::score_t score,
	output logic [tetris_pkg::board_rows*tetris_pkg::board_cols-1:0] tetris
);

	tetris_pkg::ctrl_state_t state;
	logic take;
	logic game_end;
	logic fail_flag;
	tetris_pkg::shape_t shape;
	tetris_pkg::col_t column;
	tetris_pkg::height_t land_row;
	tetris_pkg::score_t score_int;
	tetris_pkg::map_row_t [tetris_pkg::map_rows-1:0] map;
	tetris_pkg::height_t [tetris_pkg::board_cols-1:0] heights;

	piece_control #(
		.game_len(game_len)
	) u_ctrl (
		.clk(clk),
		.rst_n(rst_n),
		.in_valid(in_valid),
		.fail_flag(fail_flag),
		.score_in(score_int),
		// visible rows only, row 0 in the low bits
		.board_in(map[tetris_pkg::board_rows-1:0]),
		.state(state),
		.take(take),
		.game_end(game_end),
		.score_valid(score_valid),
		.fail(fail),
		.tetris_valid(tetris_valid),
		.score(score),
		.tetris(tetris)
	);

	drop_calc u_drop (
		.clk(clk),
		.rst_n(rst_n),
		.take(take),
		.tetromino(tetromino),
		.position(position),
		.heights(heights),
		.shape(shape),
		.column(column),
		.land_row(land_row)
	);

	board_store u_board (
		.clk(clk),
		.rst_n(rst_n),
		.state(state),
		.game_end(game_end),
		.shape(shape),
		.column(column),
		.land_row(land_row),
		.map(map),
		.score_out(score_int)
	);

	height_tracker u_height (
		.clk(clk),
		.rst_n(rst_n),
		.state(state),
		.game_end(game_end),
		.map(map),
		.heights(heights),
		.fail_flag(fail_flag)
	);

endmodule

// ==== sim/tb_tetris.sv ====
`timescale 1ns/1ps

module tb_tetris;

	localparam int board_w = tetris_pkg::board_rows * tetris_pkg::board_cols;
	localparam int max_tests = 64;

	logic clk;
	logic rst_n;
	logic in_valid;
	tetris_pkg::shape_t tetromino;
	tetris_pkg::col_t position;
	logic score_valid;
	logic fail;
	logic tetris_valid;
	tetris_pkg::score_t score;
	logic [board_w-1:0] tetris;

	// one entry per data line
	string t_name [max_tests];
	logic [2:0] t_shape [max_tests];
	logic [2:0] t_pos [max_tests];
	logic [3:0] t_score [max_tests];
	logic t_fail [max_tests];
	logic t_tv [max_tests];
	logic [board_w-1:0] t_board [max_tests];
	int n_tests;
	int errors;
	logic data_ready;

	tetris_top #(
		.game_len(tetris_pkg::pieces_per_game)
	) u_dut (
		.clk(clk),
		.rst_n(rst_n),
		.in_valid(in_valid),
		.tetromino(tetromino),
		.position(position),
		.score_valid(score_valid),
		.fail(fail),
		.tetris_valid(tetris_valid),
		.score(score),
		.tetris(tetris)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// ----------------------------------------------------------
	// test data
	// ----------------------------------------------------------
	task automatic load_tests();
		int fd;
		int n_read;
		string line;
		string name;
		int shape_v;
		int pos_v;
		int score_v;
		int fail_v;
		int tv_v;
		logic [board_w-1:0] board_v;
		n_tests = 0;
		fd = $fopen("sim/tetris_testdata.txt", "r");
		if (fd == 0) begin
			$display("could not open sim/tetris_testdata.txt");
			errors++;
			return;
		end
		while (!$feof(fd)) begin
			line = "";
			n_read = $fgets(line, fd);
			// skip comments and blank lines
			if (line.len() < 2 || line.getc(0) == "#")
				continue;
			n_read = $sscanf(line, "%s %d %d %d %d %d %h", name, shape_v, pos_v,
				score_v, fail_v, tv_v, board_v);
			if (n_read != 7) begin
				$display("malformed line in test data: %s", line);
				errors++;
			end else if (n_tests >= max_tests) begin
				$display("too many lines in test data, %s dropped", name);
				errors++;
			end else begin
				t_name[n_tests] = name;
				t_shape[n_tests] = 3'(shape_v);
				t_pos[n_tests] = 3'(pos_v);
				t_score[n_tests] = 4'(score_v);
				t_fail[n_tests] = (fail_v != 0);
				t_tv[n_tests] = (tv_v != 0);
				t_board[n_tests] = board_v;
				n_tests++;
			end
		end
		$fclose(fd);
	endtask

	// all outputs must be quiet outside the report cycle
	task automatic check_idle(input string test);
		if (score_valid) begin
			$display("unexpected score_valid outside the report cycle in %s", test);
			errors++;
		end
		if (fail || tetris_valid || score != '0 || tetris != '0) begin
			$display("FAILED %s: idle expected 0, actual fail=%0b tv=%0b score=%0d tetris=%0h",
				test, fail, tetris_valid, score, tetris);
			errors++;
		end
	endtask

	task automatic run_piece(input int i);
		int cycles;
		bit seen;
		logic [board_w-1:0] exp_board;
		@(posedge clk);
		in_valid <= 1'b1;
		tetromino <= tetris_pkg::shape_t'(t_shape[i]);
		position <= t_pos[i];
		@(posedge clk);
		in_valid <= 1'b0;
		cycles = 0;
		seen = 1'b0;
		// report is the third cycle after the in_valid cycle
		while (!seen && cycles < 6) begin
			@(negedge clk);
			cycles++;
			if (score_valid)
				seen = 1'b1;
			else
				check_idle(t_name[i]);
		end
		if (!seen) begin
			$display("score_valid never came for %s", t_name[i]);
			errors++;
			return;
		end
		if (cycles != 3) begin
			$display("FAILED %s: score_valid cycle expected 3, actual %0d", t_name[i], cycles);
			errors++;
		end
		if (score !== t_score[i]) begin
			$display("FAILED %s: score expected %0d, actual %0d", t_name[i], t_score[i], score);
			errors++;
		end
		if (fail !== t_fail[i]) begin
			$display("FAILED %s: fail expected %0b, actual %0b", t_name[i], t_fail[i], fail);
			errors++;
		end
		if (tetris_valid !== t_tv[i]) begin
			$display("FAILED %s: tetris_valid expected %0b, actual %0b", t_name[i], t_tv[i],
				tetris_valid);
			errors++;
		end
		exp_board = t_tv[i] ? t_board[i] : '0;
		if (tetris !== exp_board) begin
			$display("FAILED %s: tetris expected %018h, actual %018h", t_name[i], exp_board, tetris);
			errors++;
		end
		// report lasts one cycle only
		@(negedge clk);
		check_idle(t_name[i]);
	endtask

	// ----------------------------------------------------------
	// main sequence
	// ----------------------------------------------------------
	initial begin : main
		rst_n = 1'b0;
		in_valid = 1'b0;
		tetromino = tetris_pkg::shape_square;
		position = '0;
		errors = 0;
		data_ready = 1'b0;
		load_tests();
		if (n_tests == 0) begin
			$display("no usable lines in the test data");
			errors++;
		end
		data_ready = 1'b1;
		repeat (3) @(posedge clk);
		rst_n <= 1'b1;
		repeat (4) begin
			@(negedge clk);
			check_idle("after_reset");
		end
		for (int i = 0; i < n_tests; i++) begin
			run_piece(i);
		end
		$display("pieces run: %0d, errors: %0d", n_tests, errors);
		if (errors == 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

	// about 6 cycles per piece, so 8 leaves room
	initial begin : watchdog
		wait (data_ready);
		repeat (n_tests * 8 + 100) @(posedge clk);
		$display("watchdog expired before all pieces were done");
		$display("TEST FAILED");
		$finish;
	end

endmodule

// ==== sim/tetris_testdata.txt ====
# name shape position score fail tetris_valid board
# board is hex, bit row*6+col, row 0 at the bottom, checked only when tetris_valid is 1

# game 1: every shape on an uneven stack, single and double clears, 16 pieces
g1_hbar_floor         2 0 0 0 0 0
g1_square_clear       0 4 1 0 0 0
g1_hook_r_gap         3 0 1 0 0 0
g1_hook_l_step        4 2 1 0 0 0
g1_foot_on_step       5 3 1 0 0 0
g1_s_vert_right       6 4 1 0 0 0
g1_z_flat_left        7 0 1 0 0 0
g1_vbar_left          1 0 1 0 0 0
g1_vbar_right_clear   1 5 2 0 0 0
g1_vbar_double_clear  1 2 4 0 0 0
g1_hook_r_high        3 3 4 0 0 0
g1_s_vert_overhang    6 1 4 0 0 0
g1_hook_l_right       4 3 4 0 0 0
g1_z_flat_tall        7 0 4 0 0 0
g1_foot_right         5 4 4 0 0 0
g1_square_last        0 2 4 0 1 00C716CFA3BDD757B6

# game 2: vertical bars in column 3 until the stack leaves the board
g2_vbar_1             1 3 0 0 0 0
g2_vbar_2             1 3 0 0 0 0
g2_vbar_3             1 3 0 0 0 0
g2_vbar_overflow      1 3 0 1 1 208208208208208208

# game 3: fresh board and score, one clear, then a square on a full column
g3_hbar_fresh         2 2 0 0 0 0
g3_square_clear       0 0 1 0 0 0
g3_vbar_1             1 5 1 0 0 0
g3_vbar_2             1 5 1 0 0 0
g3_vbar_3             1 5 1 0 0 0
g3_square_overflow    0 4 1 1 1 820820820820820823

// ==== files.f ====
common/tetris_pkg.sv
src/piece_control.sv
board/drop_calc.sv
board/board_store.sv
board/height_tracker.sv
src/tetris_top.sv
sim/tb_tetris.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e

# run from the project root so the test data path resolves
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps -j 0 --top-module tb_tetris -f files.f

./obj_dir/Vtb_tetris | tee sim.log

if grep -q "TEST OK" sim.log; then
	echo "simulation passed"
else
	echo "simulation failed"
	exit 1
fi
